/* design/irq_ctrl.sv */
// interrupt dispatcher top with edge capture, priority select and host dispatch
`include "irq_defines.svh"
`timescale 1ns/10ps
`default_nettype none

module irq_ctrl (
  input  logic                 clk,
  input  logic                 rst_n,
  // request lines, active high, edge sensitive
  input  logic [`IRQ_NUM-1:0]  irq,
  // mask load strobe and new mask value
  input  logic                 mask_we,
  input  logic [`IRQ_NUM-1:0]  mask_data,
  // host side
  input  logic                 vec_ack,
  output logic                 vec_valid,
  output logic [`IRQ_ID_W-1:0] vec_id
);

  // pend, selection and claim between the stages
  irq_stage_if stg_if0 ();

  // stage one
  // edge capture, pending bits, mask
  irq_latch latch0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .irq       (irq),
    .mask_we   (mask_we),
    .mask_data (mask_data),
    .stg       (stg_if0.latch_mp)
  );

  // stage two
  // registered priority pick
  irq_select select0 (
    .clk   (clk),
    .rst_n (rst_n),
    .stg   (stg_if0.select_mp)
  );

  // stage three
  // claim and host handshake
  irq_dispatch dispatch0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .vec_ack   (vec_ack),
    .vec_valid (vec_valid),
    .vec_id    (vec_id),
    .stg       (stg_if0.dispatch_mp)
  );

endmodule

`default_nettype wire

/* design/irq_defines.svh */
// irq dispatcher sizing constants and encoder priority direction
`ifndef IRQ_DEFINES_SVH
`define IRQ_DEFINES_SVH

`default_nettype none

// number of edge-triggered request lines
`define IRQ_NUM 32

// width of a line index, log2 of IRQ_NUM
`define IRQ_ID_W 5

// encoder direction
// 0 lets the lowest line win, 1 the highest
`define IRQ_MSB_FIRST 1'b0

`default_nettype wire

`endif

/* design/irq_dispatch.sv */
// stage three, claims a selection and holds its id for the host until acknowledged
`timescale 1ns/10ps
`default_nettype none

module irq_dispatch (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             vec_ack,
  output logic             vec_valid,
  output irq_pkg::irq_id_t vec_id,
  irq_stage_if.dispatch_mp stg
);

  irq_pkg::disp_state_t state;
  // high for the edge right after an ack
  logic                 freed_q;
  // claim decision for this edge
  logic                 take;

  // accept only when idle and not just released
  // gives one idle edge between vectors
  assign take = (state == irq_pkg::disp_idle) && stg.sel_valid && !freed_q;

  // two-state control plus the claim pulse
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= irq_pkg::disp_idle;
      freed_q   <= 1'b0;
      stg.claim <= 1'b0;
    end else begin
      // claim rises together with vec_valid
      stg.claim <= take;
      freed_q   <= 1'b0;
      case (state)
        irq_pkg::disp_idle: begin
          if (take) begin
            state <= irq_pkg::disp_busy;
          end
        end
        irq_pkg::disp_busy: begin
          // ack is ignored while idle
          if (vec_ack) begin
            state   <= irq_pkg::disp_idle;
            freed_q <= 1'b1;
          end
        end
      endcase
    end
  end

  // ids captured at claim time, held while busy
  always_ff @(posedge clk) begin
    if (take) begin
      vec_id       <= stg.sel_id;
      stg.claim_id <= stg.sel_id;
    end
  end

  // level to the host for the whole busy period
  assign vec_valid = (state == irq_pkg::disp_busy);

endmodule

`default_nettype wire

/* design/irq_latch.sv */
// stage one, edge capture into pending bits plus the line mask register
`include "irq_defines.svh"
`timescale 1ns/10ps
`default_nettype none

module irq_latch (
  input  logic              clk,
  input  logic              rst_n,
  input  irq_pkg::irq_vec_t irq,
  input  logic              mask_we,
  input  irq_pkg::irq_vec_t mask_data,
  irq_stage_if.latch_mp     stg
);

  // previous request levels for edge detect
  irq_pkg::irq_vec_t irq_q;
  // rising edges seen this cycle
  irq_pkg::irq_vec_t rise;
  // one-hot clear from the claim
  irq_pkg::irq_vec_t clr;
  // sticky pending bits, masked or not
  irq_pkg::irq_vec_t pending;
  // 1 hides the line from selection
  irq_pkg::irq_vec_t mask;

  // request history, plain pipeline register
  always_ff @(posedge clk) begin
    irq_q <= irq;
  end

  // low-to-high transitions only
  assign rise = irq & ~irq_q;

  // decode claim_id into the bit to drop
  always_comb begin
    int i;
    clr = '0;
    for (i = 0; i < `IRQ_NUM; i = i + 1) begin
      clr[i] = stg.claim && (stg.claim_id == irq_pkg::irq_id_t'(i));
    end
  end

  // pending bits
  // a new edge in the claim cycle re-arms the line
  // repeated edges on a pending line simply merge
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pending <= '0;
    end else begin
      pending <= (pending & ~clr) | rise;
    end
  end

  // mask register, loaded by a one-cycle strobe
  // all lines unmasked out of reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mask <= '0;
    end else if (mask_we) begin
      mask <= mask_data;
    end
  end

  // masked lines stay pending but are not offered downstream
  assign stg.pend = pending & ~mask;

endmodule

`default_nettype wire

/* design/irq_pkg.sv */
// shared types for the interrupt dispatcher pipeline
`include "irq_defines.svh"
`default_nettype none

package irq_pkg;

  // one bit per request line
  // used for raw requests, pending bits, mask and claim vector
  typedef logic [`IRQ_NUM-1:0] irq_vec_t;

  // index of a single request line
  typedef logic [`IRQ_ID_W-1:0] irq_id_t;

  // dispatch stage state
  // idle   no vector shown to the host
  // busy   vec_id held until vec_ack
  typedef enum logic {
    disp_idle = 1'b0,
    disp_busy = 1'b1
  } disp_state_t;

endpackage

`default_nettype wire

/* design/irq_select.sv */
// stage two, priority encode of the visible pending bits with one cycle of latency
`include "irq_defines.svh"
`timescale 1ns/10ps
`default_nettype none

module irq_select (
  input  logic           clk,
  input  logic           rst_n,
  irq_stage_if.select_mp stg
);

  // raw encoder result
  logic             enc_valid;
  irq_pkg::irq_id_t enc_id;

  // lowest index wins unless the direction macro says otherwise
  pri_enc #(
    .IN  (`IRQ_NUM),
    .MSB (`IRQ_MSB_FIRST)
  ) enc0 (
    .in    (stg.pend),
    .valid (enc_valid),
    .out   (enc_id)
  );

  // selection valid flag
  // pend still shows the claimed bit during the claim cycle
  // so that result is dropped instead of registered
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stg.sel_valid <= 1'b0;
    end else if (stg.claim) begin
      stg.sel_valid <= 1'b0;
    end else begin
      stg.sel_valid <= enc_valid;
    end
  end

  // index only matters while sel_valid is high
  always_ff @(posedge clk) begin
    stg.sel_id <= enc_id;
  end

endmodule

`default_nettype wire

/* design/irq_stage_if.sv */
// stage-to-stage bundle linking latch, select and dispatch stages
`timescale 1ns/10ps
`default_nettype none

interface irq_stage_if;

  // pending bits with masked lines already removed
  irq_pkg::irq_vec_t pend;

  // registered encoder result from stage two
  logic              sel_valid;
  irq_pkg::irq_id_t  sel_id;

  // one-cycle claim pulse from the dispatcher
  logic              claim;
  irq_pkg::irq_id_t  claim_id;

  // stage one clears the claimed bit
  modport latch_mp (
    output pend,
    input  claim,
    input  claim_id
  );

  // stage two flushes its result on a claim
  modport select_mp (
    input  pend,
    input  claim,
    output sel_valid,
    output sel_id
  );

  // stage three takes the selection
  modport dispatch_mp (
    input  sel_valid,
    input  sel_id,
    output claim,
    output claim_id
  );

endinterface

`default_nettype wire

/* design/pri_enc.sv */
// parameterized priority encoder returning the index of the winning set bit
`timescale 1ns/10ps
`default_nettype none

module pri_enc #(
  // number of request inputs
  parameter int IN  = 32,
  // 0 lets bit 0 win, 1 lets bit IN-1 win
  parameter bit MSB = 1'b0,
  // index width, derived
  parameter int OUT = $clog2(IN)
) (
  input  logic [IN-1:0]  in,
  output logic           valid,
  output logic [OUT-1:0] out
);

  // one-hot copy of the winning input
  logic [IN-1:0] win;

  // positions that outrank pos in the chosen direction
  function automatic logic [IN-1:0] ahead_mask(input int pos);
    logic [IN-1:0] m;
    int            i;
    for (i = 0; i < IN; i = i + 1) begin
      if (MSB) begin
        m[i] = (i > pos);
      end else begin
        m[i] = (i < pos);
      end
    end
    return m;
  endfunction

  // positions whose own index has bit b set
  function automatic logic [IN-1:0] idx_mask(input int b);
    logic [IN-1:0] m;
    int            i;
    for (i = 0; i < IN; i = i + 1) begin
      m[i] = (((i >> b) & 1) != 0);
    end
    return m;
  endfunction

  // any request at all
  assign valid = |in;

  // bit isolation
  // a position wins only if nothing ahead of it is set
  for (genvar gj = 0; gj < IN; gj++) begin : g_win
    localparam logic [IN-1:0] AHEAD = ahead_mask(gj);

    assign win[gj] = in[gj] & ~(|(in & AHEAD));
  end

  // index build
  // each output bit ORs the winners whose index carries that bit
  for (genvar gi = 0; gi < OUT; gi++) begin : g_out
    localparam logic [IN-1:0] IDX = idx_mask(gi);

    assign out[gi] = |(win & IDX);
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+design
design/irq_pkg.sv
design/irq_stage_if.sv
design/pri_enc.sv
design/irq_latch.sv
design/irq_select.sv
design/irq_dispatch.sv
design/irq_ctrl.sv
testbench/tb_irq_ctrl.sv

/* testbench/tb_irq_ctrl.sv */
// interrupt dispatcher testbench, random traffic checked against a reference model
`include "irq_defines.svh"
`timescale 1ns/10ps
`default_nettype none

module tb_irq_ctrl;

  // five tests of roughly 600 cycles plus margin
  localparam int CYCLE_LIMIT = 4000;
  localparam int DRAIN_LIMIT = 600;

  logic              clk;
  logic              rst_n;
  irq_pkg::irq_vec_t irq;
  logic              mask_we;
  irq_pkg::irq_vec_t mask_data;
  logic              vec_ack;
  logic              vec_valid;
  irq_pkg::irq_id_t  vec_id;

  integer seed;
  int     cyc = 0;
  int     errors;
  int     tests_run;
  int     tests_failed;

  // model state
  irq_pkg::irq_vec_t m_pend;
  irq_pkg::irq_vec_t m_mask;
  irq_pkg::irq_vec_t m_irq_q;
  // cycles each line has been pending and unmasked
  int                age [`IRQ_NUM];
  int                disp_cnt [`IRQ_NUM];
  int                periods;
  int                dispatched;
  logic              claim_flag;
  irq_pkg::irq_id_t  claim_id_m;

  // host model
  logic host_busy;
  logic ack_hold;
  int   ack_wait;
  int   ack_span;
  int   last_ack_drv;

  logic             mon_on;
  logic             prev_valid;
  irq_pkg::irq_id_t prev_id;

  irq_ctrl dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .irq       (irq),
    .mask_we   (mask_we),
    .mask_data (mask_data),
    .vec_ack   (vec_ack),
    .vec_valid (vec_valid),
    .vec_id    (vec_id)
  );

  always #5 clk = ~clk;

  // cycle count and run limit
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= CYCLE_LIMIT) begin
      $display("timed out after %0d cycles, dispatcher or host stuck", CYCLE_LIMIT);
      $display("Testbench failed");
      $finish;
    end
  end

  function automatic int rand_below(input int n);
    return {$random(seed)} % n;
  endfunction

  task automatic flag_error(input string msg);
    $display("FAILED @%0t: %s", $time, msg);
    errors++;
  endtask

  // one clock edge of the model, using the inputs the DUT just sampled
  task automatic model_edge();
    irq_pkg::irq_vec_t rise;
    irq_pkg::irq_vec_t clr;
    irq_pkg::irq_vec_t kept;
    irq_pkg::irq_vec_t vis_old;
    irq_pkg::irq_vec_t vis_new;
    int                i;
    rise = irq & ~m_irq_q;
    clr  = '0;
    // a claim clears its line one edge after vec_valid rose
    if (claim_flag) begin
      clr[claim_id_m] = 1'b1;
      claim_flag      = 1'b0;
    end
    vis_old = m_pend & ~m_mask;
    kept    = m_pend & ~clr;
    for (i = 0; i < `IRQ_NUM; i++) begin
      // edge on a line not still pending opens a new period
      if (rise[i] && !kept[i]) begin
        periods++;
      end
    end
    m_pend = kept | rise;
    if (mask_we) begin
      m_mask = mask_data;
    end
    vis_new = m_pend & ~m_mask;
    for (i = 0; i < `IRQ_NUM; i++) begin
      if (!vis_new[i]) begin
        age[i] = 0;
      end else if (vis_old[i] && !clr[i]) begin
        age[i] = age[i] + 1;
      end else begin
        age[i] = 1;
      end
    end
    m_irq_q = irq;
  endtask

  // host ack after its random delay, one-cycle pulse
  task automatic host_drive();
    vec_ack = 1'b0;
    if (host_busy && !ack_hold) begin
      if (ack_wait == 0) begin
        vec_ack      = 1'b1;
        host_busy    = 1'b0;
        last_ack_drv = cyc;
      end else begin
        ack_wait--;
      end
    end
  endtask

  // advance one cycle, inputs change 1 ns after the edge
  task automatic tick(input irq_pkg::irq_vec_t irq_v, input logic we_v,
                      input irq_pkg::irq_vec_t md_v);
    @(posedge clk);
    #1;
    model_edge();
    irq       = irq_v;
    mask_we   = we_v;
    mask_data = md_v;
    host_drive();
  endtask

  // sparse pulses, about one line every eight cycles
  task automatic random_traffic(input int n);
    irq_pkg::irq_vec_t v;
    int                k;
    for (k = 0; k < n; k++) begin
      v = '0;
      if (rand_below(8) == 0) begin
        v[rand_below(`IRQ_NUM)] = 1'b1;
      end
      tick(v, 1'b0, '0);
    end
  endtask

  // idle until nothing visible is pending and the host is done
  task automatic drain();
    int quiet;
    int k;
    quiet = 0;
    k     = 0;
    while (quiet < 4 && k < DRAIN_LIMIT) begin
      tick('0, 1'b0, '0);
      if (((m_pend & ~m_mask) == '0) && !vec_valid && !host_busy) begin
        quiet++;
      end else begin
        quiet = 0;
      end
      k++;
    end
    if (quiet < 4) begin
      $display("pending requests were not all serviced within %0d cycles", DRAIN_LIMIT);
      errors++;
    end
  endtask

  task automatic wait_valid(input int limit);
    int k;
    k = 0;
    while (!vec_valid && k < limit) begin
      tick('0, 1'b0, '0);
      k++;
    end
    if (!vec_valid) begin
      $display("vec_valid did not rise within %0d cycles", limit);
      errors++;
    end
  endtask

  // every request period dispatched exactly once
  task automatic check_totals();
    if (dispatched != periods) begin
      flag_error($sformatf("%0d request periods but %0d dispatches", periods, dispatched));
    end
    if (m_pend != '0) begin
      flag_error($sformatf("lines %h still pending after drain", m_pend));
    end
  endtask

  task automatic finish_test(input string name, input int err0);
    tests_run++;
    if (errors == err0) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - err0);
    end
  endtask

  // new vector, checked against model priority and timing
  task automatic check_claim();
    int j;
    if (cyc - last_ack_drv < 3) begin
      flag_error($sformatf("vector %0d cycles after vec_ack", cyc - last_ack_drv));
    end
    if (m_mask[vec_id]) begin
      flag_error($sformatf("masked line %0d dispatched", vec_id));
    end
    if (age[vec_id] < 3) begin
      flag_error($sformatf("line %0d dispatched without a visible request", vec_id));
    end
    for (j = 0; j < int'(vec_id); j++) begin
      if (age[j] >= 3) begin
        flag_error($sformatf("line %0d outranks dispatched line %0d", j, vec_id));
      end
    end
    claim_flag = 1'b1;
    claim_id_m = vec_id;
    disp_cnt[vec_id]++;
    dispatched++;
    host_busy = 1'b1;
    ack_wait  = rand_below(ack_span + 1);
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    if (mon_on) begin
      if (vec_valid && !prev_valid) begin
        check_claim();
      end
      if (vec_valid && prev_valid && vec_id != prev_id) begin
        flag_error("vec_id changed while vec_valid held");
      end
      if (!vec_valid && prev_valid && last_ack_drv != cyc - 1) begin
        flag_error("vec_valid fell without vec_ack");
      end
      if (vec_valid && last_ack_drv == cyc - 1) begin
        flag_error("vec_valid still high the cycle after vec_ack");
      end
      prev_valid = vec_valid;
      prev_id    = vec_id;
    end
  end

  initial begin
    irq_pkg::irq_vec_t v;
    irq_pkg::irq_vec_t held;
    int                snap [`IRQ_NUM];
    int                err0;
    int                n;
    int                line;
    int                req_cyc;
    clk       = 1'b0;
    rst_n     = 1'b0;
    irq       = '0;
    mask_we   = 1'b0;
    mask_data = '0;
    vec_ack   = 1'b0;
    seed      = 26712;
    errors    = 0;
    tests_run = 0;
    tests_failed = 0;
    m_pend    = '0;
    m_mask    = '0;
    m_irq_q   = '0;
    periods   = 0;
    dispatched = 0;
    claim_flag = 1'b0;
    host_busy = 1'b0;
    ack_hold  = 1'b0;
    ack_wait  = 0;
    ack_span  = 6;
    last_ack_drv = -100;
    mon_on    = 1'b0;
    prev_valid = 1'b0;
    for (n = 0; n < `IRQ_NUM; n++) begin
      age[n]      = 0;
      disp_cnt[n] = 0;
    end
    repeat (16) @(posedge clk);
    #1;
    rst_n  = 1'b1;
    mon_on = 1'b1;

    // quiet after reset, then lone requests with fixed latency
    err0 = errors;
    repeat (10) begin
      tick('0, 1'b0, '0);
      if (vec_valid) begin
        flag_error("vec_valid high with no request");
      end
    end
    for (n = 0; n < 4; n++) begin
      line = rand_below(`IRQ_NUM);
      v = '0;
      v[line] = 1'b1;
      tick(v, 1'b0, '0);
      req_cyc = cyc;
      wait_valid(10);
      if (vec_valid && cyc - req_cyc != 3) begin
        flag_error($sformatf("latency %0d cycles, expected 3", cyc - req_cyc));
      end
      if (vec_valid && int'(vec_id) != line) begin
        flag_error($sformatf("vec_id %0d, expected %0d", vec_id, line));
      end
      drain();
    end
    check_totals();
    finish_test("single request", err0);

    // priority under random traffic
    err0 = errors;
    random_traffic(400);
    drain();
    check_totals();
    finish_test("random priority", err0);

    // masked lines keep their pending bits until unmasked
    err0 = errors;
    v = $random(seed);
    tick('0, 1'b1, v | 32'h0000_00f0);
    random_traffic(300);
    tick(32'h0000_00f0, 1'b0, '0);
    drain();
    held = m_pend & m_mask;
    for (n = 0; n < `IRQ_NUM; n++) begin
      snap[n] = disp_cnt[n];
    end
    tick('0, 1'b1, '0);
    drain();
    for (n = 0; n < `IRQ_NUM; n++) begin
      if (held[n] && disp_cnt[n] == snap[n]) begin
        flag_error($sformatf("line %0d not dispatched after unmask", n));
      end
    end
    check_totals();
    finish_test("masking", err0);

    // repeated edges merge into one pending period
    err0 = errors;
    snap[3] = disp_cnt[3];
    snap[7] = disp_cnt[7];
    ack_hold = 1'b1;
    tick(32'h0000_0008, 1'b0, '0);
    wait_valid(10);
    for (n = 0; n < 3; n++) begin
      tick((n < 2) ? 32'h0000_0088 : 32'h0000_0080, 1'b0, '0);
      tick('0, 1'b0, '0);
    end
    ack_hold = 1'b0;
    drain();
    if (disp_cnt[7] - snap[7] != 1 || disp_cnt[3] - snap[3] != 2) begin
      flag_error($sformatf("line 3 sent %0d times, line 7 sent %0d times, expected 2 and 1",
                           disp_cnt[3] - snap[3], disp_cnt[7] - snap[7]));
    end
    // dense pulses on three lines hit the claim edge
    ack_span = 2;
    for (n = 0; n < 200; n++) begin
      v = '0;
      if (rand_below(3) == 0) begin
        v[1 + rand_below(3)] = 1'b1;
      end
      tick(v, 1'b0, '0);
    end
    ack_span = 6;
    drain();
    check_totals();
    finish_test("single service", err0);

    // host holds off, then acks at once
    err0 = errors;
    ack_hold = 1'b1;
    tick(32'h0000_1000, 1'b0, '0);
    random_traffic(80);
    if (!vec_valid) begin
      flag_error("no vector held under back-pressure");
    end
    ack_span = 0;
    ack_hold = 1'b0;
    random_traffic(150);
    ack_span = 6;
    random_traffic(100);
    drain();
    check_totals();
    finish_test("back-pressure", err0);

    $display("tests run %0d, tests failed %0d, checks failed %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
